/* sim.f */
design/fpu_pkg.sv
design/fpu_op_decode.sv
design/fpu_pipe_ctrl.sv
design/fpu_noncomp_lane.sv
design/fpu_noncomp_unit.sv
testbench/tb_fpu_noncomp.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    --top-module tb_fpu_noncomp \
    -f sim.f \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* testbench/tb_fpu_noncomp.sv */
module tb_fpu_noncomp;
    import fpu_pkg::*;

    typedef logic [NUM_THREADS-1:0][31:0]            lanes_t;
    typedef logic [NUM_THREADS-1:0][FFLAGS_BITS-1:0] flags_t;

    localparam int          TIMEOUT_CYCLES = 4000;    // Far above what all tests need
    localparam logic [31:0] QNAN  = CANONICAL_NAN;
    localparam logic [31:0] QNAN2 = 32'hffc1_2345;    // Negative qNaN with payload
    localparam logic [31:0] SNAN  = 32'h7f80_0001;
    localparam logic [31:0] SNAN2 = 32'hffa0_0000;
    localparam logic [31:0] PZERO = 32'h0000_0000;
    localparam logic [31:0] NZERO = 32'h8000_0000;
    localparam logic [31:0] ONE   = 32'h3f80_0000;
    localparam logic [31:0] MTWO  = 32'hc000_0000;
    localparam logic [31:0] PINF  = 32'h7f80_0000;
    localparam logic [31:0] NINF  = 32'hff80_0000;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  valid_i;
    logic                  ready_o;
    logic [TAG_BITS-1:0]   tag_i;
    fpu_op_e               op_type_i;
    logic [FRM_BITS-1:0]   frm_i;
    lanes_t                dataa_i;
    lanes_t                datab_i;
    logic                  valid_o;
    logic                  ready_i = 1'b1;
    logic [TAG_BITS-1:0]   tag_o;
    lanes_t                result_o;
    flags_t                fflags_o;
    logic                  has_fflags_o;

    integer                seed;
    integer                bp_seed;
    int                    cyc = 0;
    logic                  bp_random = 1'b0;
    logic                  lat_check = 1'b1;
    logic [TAG_BITS-1:0]   next_tag = '0;

    lanes_t                exp_res_q[$];
    flags_t                exp_fl_q[$];
    logic [TAG_BITS-1:0]   exp_tag_q[$];
    logic                  exp_hf_q[$];
    int                    acc_cyc_q[$];

    logic                  stalled = 1'b0;
    logic [TAG_BITS-1:0]   held_tag;
    lanes_t                held_res;
    flags_t                held_fl;
    logic                  held_hf;

    fpu_noncomp_unit dut0 (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .tag_i        (tag_i),
        .op_type_i    (op_type_i),
        .frm_i        (frm_i),
        .dataa_i      (dataa_i),
        .datab_i      (datab_i),
        .valid_o      (valid_o),
        .ready_i      (ready_i),
        .tag_o        (tag_o),
        .result_o     (result_o),
        .fflags_o     (fflags_o),
        .has_fflags_o (has_fflags_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_result(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s expected %h got %h",
                                     $time, name, exp, got));
        end
    endtask

    task automatic check_fflags(input string name, input logic [FFLAGS_BITS-1:0] exp,
                                input logic [FFLAGS_BITS-1:0] got);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s expected %b got %b",
                                     $time, name, exp, got));
        end
    endtask

    task automatic check_tag(input string name, input logic [TAG_BITS-1:0] exp_tag,
                             input logic [TAG_BITS-1:0] got_tag, input logic exp_hf,
                             input logic got_hf);
        if (got_tag !== exp_tag) begin
            report_failure($sformatf("Mismatch at %0t: %s expected %h got %h",
                                     $time, name, exp_tag, got_tag));
        end else if (got_hf !== exp_hf) begin
            report_failure($sformatf("Mismatch at %0t: has_fflags_o expected %b got %b",
                                     $time, exp_hf, got_hf));
        end
    endtask

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // Unsigned key that sorts like the real line with -0 just below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [31:0] ref_sgnj(input logic [2:0] frm, input logic [31:0] a,
                                             input logic [31:0] b);
        case (frm)
            3'd1:    return {~b[31], a[30:0]};
            3'd2:    return {a[31] ^ b[31], a[30:0]};
            default: return {b[31], a[30:0]};
        endcase
    endfunction

    function automatic logic [31:0] ref_minmax(input logic is_max, input logic [31:0] a,
                                               input logic [31:0] b, output logic nv);
        logic a_lt;
        nv   = is_snan(a) || is_snan(b);
        a_lt = order_key(a) < order_key(b);
        if (is_nan(a) && is_nan(b)) return CANONICAL_NAN;
        else if (is_nan(a)) return b;
        else if (is_nan(b)) return a;
        else if (is_max) return a_lt ? b : a;
        else return a_lt ? a : b;
    endfunction

    function automatic logic [31:0] ref_compare(input logic [2:0] frm, input logic [31:0] a,
                                                input logic [31:0] b, output logic nv);
        logic any_nan;
        logic eq;
        logic lt;
        any_nan = is_nan(a) || is_nan(b);
        eq      = (a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0));
        lt      = (order_key(a) < order_key(b)) && !eq;
        case (frm)
            3'd0: begin
                nv = any_nan;
                return {31'd0, !any_nan && (lt || eq)};
            end
            3'd1: begin
                nv = any_nan;
                return {31'd0, !any_nan && lt};
            end
            default: begin
                nv = is_snan(a) || is_snan(b);    // FEQ is quiet
                return {31'd0, !any_nan && eq};
            end
        endcase
    endfunction

    function automatic logic [CLASS_BITS-1:0] ref_classify(input logic [31:0] x);
        int idx;
        if (is_nan(x)) idx = x[22] ? 9 : 8;
        else if (x[30:23] == 8'hff) idx = x[31] ? 0 : 7;
        else if (x[30:0] == 31'd0) idx = x[31] ? 3 : 4;
        else if (x[30:23] == 8'h00) idx = x[31] ? 2 : 5;
        else idx = x[31] ? 1 : 6;
        return CLASS_BITS'(1) << idx;
    endfunction

    function automatic logic [31:0] ref_lane(input fpu_op_e op, input logic [2:0] frm,
                                             input logic [31:0] a, input logic [31:0] b,
                                             output logic [FFLAGS_BITS-1:0] fl);
        logic        nv;
        logic [31:0] res;
        nv = 1'b0;
        fl = '0;
        case (op)
            FPU_MISC: begin
                if (frm == 3'd3 || frm == 3'd4) res = ref_minmax(frm == 3'd4, a, b, nv);
                else res = ref_sgnj(frm, a, b);
            end
            FPU_CMP:   res = ref_compare(frm, a, b, nv);
            FPU_CLASS: res = {{(32 - CLASS_BITS){1'b0}}, ref_classify(a)};
            default: begin
                res = 32'd0;
                nv  = 1'b1;    // Not handled by this unit
            end
        endcase
        fl[FLAG_NV] = nv;
        return res;
    endfunction

    function automatic logic ref_has_fflags(input fpu_op_e op, input logic [2:0] frm);
        if (op == FPU_CLASS) return 1'b0;
        else if (op == FPU_MISC) return frm == 3'd3 || frm == 3'd4;
        else return 1'b1;
    endfunction

    function automatic lanes_t rand_lanes();
        lanes_t v;
        for (int i = 0; i < NUM_THREADS; i++) v[i] = $random(seed);
        return v;
    endfunction

    // Runs from posedge + 1 to posedge + 1 after the accept edge
    task automatic send_req(input fpu_op_e op, input logic [2:0] frm, input lanes_t a,
                            input lanes_t b);
        lanes_t                 exp_res;
        flags_t                 exp_fl;
        logic [FFLAGS_BITS-1:0] fl;
        for (int i = 0; i < NUM_THREADS; i++) begin
            exp_res[i] = ref_lane(op, frm, a[i], b[i], fl);
            exp_fl[i]  = fl;
        end
        exp_res_q.push_back(exp_res);
        exp_fl_q.push_back(exp_fl);
        exp_tag_q.push_back(next_tag);
        exp_hf_q.push_back(ref_has_fflags(op, frm));
        valid_i   = 1'b1;
        tag_i     = next_tag;
        op_type_i = op;
        frm_i     = frm;
        dataa_i   = a;
        datab_i   = b;
        @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        acc_cyc_q.push_back(cyc);
        valid_i  = 1'b0;
        next_tag = next_tag + TAG_BITS'(1);
    endtask

    task automatic send_random_req();
        logic [31:0] r;
        fpu_op_e     op;
        r = $random(seed);
        case (r[1:0])
            2'd0:    op = FPU_CLASS;
            2'd1:    op = FPU_CMP;
            default: op = FPU_MISC;
        endcase
        send_req(op, r[4:2], rand_lanes(), rand_lanes());
    endtask

    task automatic drain();
        while (exp_tag_q.size() != 0) @(negedge clk_i);
        @(posedge clk_i);
        #1;
    endtask

    task automatic test_sign_inject();
        for (int f = 0; f < 3; f++) begin
            repeat (3) send_req(FPU_MISC, 3'(f), rand_lanes(), rand_lanes());
        end
        send_req(FPU_MISC, 3'd7, rand_lanes(), rand_lanes());    // Spare frm decodes to SGNJ
        drain();
    endtask

    task automatic test_min_max();
        for (int f = 3; f <= 4; f++) begin
            send_req(FPU_MISC, 3'(f), {NZERO, QNAN, SNAN, QNAN}, {PZERO, SNAN2, MTWO, ONE});
            send_req(FPU_MISC, 3'(f), {MTWO, QNAN, SNAN, PZERO}, {ONE, QNAN2, SNAN2, NZERO});
            send_req(FPU_MISC, 3'(f), rand_lanes(), rand_lanes());
        end
        drain();
    endtask

    task automatic test_compare();
        lanes_t r;
        for (int f = 0; f < 3; f++) begin
            r = rand_lanes();
            send_req(FPU_CMP, 3'(f), {ONE, MTWO, NZERO, ONE}, {ONE, ONE, PZERO, MTWO});
            send_req(FPU_CMP, 3'(f), {QNAN, ONE, SNAN, QNAN}, {ONE, QNAN, ONE, SNAN2});
            send_req(FPU_CMP, 3'(f), rand_lanes(), rand_lanes());
            send_req(FPU_CMP, 3'(f), r, r);
        end
        send_req(FPU_CMP, 3'd5, {QNAN, SNAN, ONE, MTWO}, {ONE, ONE, ONE, MTWO});
        drain();
    endtask

    task automatic test_classify();
        send_req(FPU_CLASS, 3'd0, {NZERO, 32'h8000_0001, 32'hbf80_0000, NINF}, rand_lanes());
        send_req(FPU_CLASS, 3'd0, {PINF, ONE, 32'h0040_0000, PZERO}, rand_lanes());
        send_req(FPU_CLASS, 3'd0, {QNAN2, SNAN2, QNAN, SNAN}, rand_lanes());
        drain();
    endtask

    task automatic test_handshake();
        repeat (8) send_random_req();    // Back to back with latency checked by the monitor
        drain();
        lat_check = 1'b0;
        bp_random = 1'b1;
        repeat (32) send_random_req();
        drain();
        bp_random = 1'b0;
        lat_check = 1'b1;
    endtask

    task automatic test_unsupported();
        send_req(FPU_ADD, 3'd0, rand_lanes(), rand_lanes());
        send_req(FPU_SQRT, 3'd3, {SNAN, QNAN, ONE, PZERO}, rand_lanes());
        send_req(FPU_CVTSWU, 3'd1, rand_lanes(), rand_lanes());
        drain();
    endtask

    always @(posedge clk_i) begin : backpressure
        logic [31:0] r;
        #1;
        if (bp_random) begin
            r       = $random(bp_seed);
            ready_i = r[0] | r[1];    // Ready about three cycles in four
        end else begin
            ready_i = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            report_failure("Timeout: the tests did not complete within the cycle limit");
        end
    end

    // Sampled at the falling edge before the rising edge that transfers
    always @(negedge clk_i) begin : monitor
        lanes_t er;
        flags_t ef;
        int     acc;
        if (stalled) begin
            if (!valid_o) report_failure("valid_o dropped while the output was stalled");
            check_tag("tag_o while stalled", held_tag, tag_o, held_hf, has_fflags_o);
            for (int i = 0; i < NUM_THREADS; i++) begin
                check_result($sformatf("result_o[%0d] while stalled", i), held_res[i], result_o[i]);
                check_fflags($sformatf("fflags_o[%0d] while stalled", i), held_fl[i], fflags_o[i]);
            end
        end
        if (valid_o && ready_i) begin
            if (exp_tag_q.size() == 0) begin
                report_failure("A result came back with no request outstanding");
            end else begin
                er  = exp_res_q.pop_front();
                ef  = exp_fl_q.pop_front();
                acc = acc_cyc_q.pop_front();
                check_tag("tag_o", exp_tag_q.pop_front(), tag_o, exp_hf_q.pop_front(),
                          has_fflags_o);
                for (int i = 0; i < NUM_THREADS; i++) begin
                    check_result($sformatf("result_o[%0d]", i), er[i], result_o[i]);
                    check_fflags($sformatf("fflags_o[%0d]", i), ef[i], fflags_o[i]);
                end
                if (lat_check && (cyc + 1 - acc) != LATENCY_NONCOMP) begin
                    report_failure($sformatf("Mismatch at %0t: latency expected %0d got %0d",
                                             $time, LATENCY_NONCOMP, cyc + 1 - acc));
                end
            end
        end
        stalled  = valid_o && !ready_i;
        held_tag = tag_o;
        held_res = result_o;
        held_fl  = fflags_o;
        held_hf  = has_fflags_o;
    end

    initial begin
        seed      = 32'h68ca;
        bp_seed   = 32'h68ca;
        arst_n_i  = 1'b0;
        valid_i   = 1'b0;
        tag_i     = '0;
        op_type_i = FPU_MISC;
        frm_i     = '0;
        dataa_i   = '0;
        datab_i   = '0;
        repeat (2) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
            report_failure("After reset valid_o should be low and ready_o high");
        end
        test_sign_inject();
        test_min_max();
        test_compare();
        test_classify();
        test_handshake();
        test_unsupported();
        repeat (LATENCY_NONCOMP + 1) @(negedge clk_i);
        if (valid_o !== 1'b0) begin
            report_failure("valid_o was high after every result had been collected");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* design/fpu_noncomp_unit.sv */
module fpu_noncomp_unit (
    input  logic                                                   clk_i,
    input  logic                                                   arst_n_i,

    input  logic                                                   valid_i,
    output logic                                                   ready_o,
    input  logic [fpu_pkg::TAG_BITS-1:0]                           tag_i,
    input  fpu_pkg::fpu_op_e                                       op_type_i,
    input  logic [fpu_pkg::FRM_BITS-1:0]                           frm_i,
    input  logic [fpu_pkg::NUM_THREADS-1:0][31:0]                  dataa_i,
    input  logic [fpu_pkg::NUM_THREADS-1:0][31:0]                  datab_i,

    output logic                                                   valid_o,
    input  logic                                                   ready_i,
    output logic [fpu_pkg::TAG_BITS-1:0]                           tag_o,
    output logic [fpu_pkg::NUM_THREADS-1:0][31:0]                  result_o,
    output logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FFLAGS_BITS-1:0] fflags_o,
    output logic                                                   has_fflags_o
);
    import fpu_pkg::*;

    fpu_unit_op_e unit_op;
    logic         has_fflags;
    logic         unsupported;
    logic         advance;

    fpu_op_decode op_decode0 (
        .op_type_i     (op_type_i),
        .frm_i         (frm_i),
        .unit_op_o     (unit_op),
        .has_fflags_o  (has_fflags),
        .unsupported_o (unsupported)
    );

    // Shared tag and handshake path for all lanes
    fpu_pipe_ctrl pipe_ctrl0 (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .tag_i        (tag_i),
        .has_fflags_i (has_fflags),
        .valid_o      (valid_o),
        .ready_i      (ready_i),
        .tag_o        (tag_o),
        .has_fflags_o (has_fflags_o),
        .advance_o    (advance)
    );

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        fpu_noncomp_lane lane (
            .clk_i         (clk_i),
            .advance_i     (advance),
            .unit_op_i     (unit_op),
            .unsupported_i (unsupported),
            .a_i           (dataa_i[i]),
            .b_i           (datab_i[i]),
            .result_o      (result_o[i]),
            .fflags_o      (fflags_o[i])
        );
    end

endmodule

/* design/fpu_noncomp_lane.sv */
module fpu_noncomp_lane (
    input  logic                              clk_i,
    input  logic                              advance_i,
    input  fpu_pkg::fpu_unit_op_e             unit_op_i,
    input  logic                              unsupported_i,
    input  logic [31:0]                       a_i,
    input  logic [31:0]                       b_i,
    output logic [31:0]                       result_o,
    output logic [fpu_pkg::FFLAGS_BITS-1:0]   fflags_o
);
    import fpu_pkg::*;

    logic [31:0]            a_q;
    logic [31:0]            b_q;
    fpu_unit_op_e           op_q;
    logic                   unsupported_q;

    logic [CLASS_BITS-1:0]  a_class;
    logic [CLASS_BITS-1:0]  b_class;
    logic                   a_nan;
    logic                   b_nan;
    logic                   any_snan;
    logic                   both_zero;
    logic                   total_lt;
    logic                   num_eq;
    logic                   num_lt;

    logic [31:0]            result_d;
    logic [FFLAGS_BITS-1:0] fflags_d;
    logic [31:0]            result_q;
    logic [FFLAGS_BITS-1:0] fflags_q;

    // Bits from 0 up are -inf -norm -sub -0 +0 +sub +norm +inf snan qnan
    function automatic logic [CLASS_BITS-1:0] classify(input logic [31:0] x);
        logic                  sign;
        logic [7:0]            exp;
        logic                  man_zero;
        logic [CLASS_BITS-1:0] mask;
        sign     = x[31];
        exp      = x[30:23];
        man_zero = (x[22:0] == 23'd0);
        mask     = '0;
        if (exp == 8'hff) begin
            if (!man_zero) begin
                mask[x[22] ? 9 : 8] = 1'b1;    // Quiet bit picks qNaN
            end else begin
                mask[sign ? 0 : 7] = 1'b1;
            end
        end else if (exp == 8'h00) begin
            if (man_zero) begin
                mask[sign ? 3 : 4] = 1'b1;
            end else begin
                mask[sign ? 2 : 5] = 1'b1;
            end
        end else begin
            mask[sign ? 1 : 6] = 1'b1;
        end
        return mask;
    endfunction

    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            a_q           <= a_i;
            b_q           <= b_i;
            op_q          <= unit_op_i;
            unsupported_q <= unsupported_i;
        end
    end

    assign a_class   = classify(a_q);
    assign b_class   = classify(b_q);
    assign a_nan     = a_class[8] | a_class[9];
    assign b_nan     = b_class[8] | b_class[9];
    assign any_snan  = a_class[8] | b_class[8];
    assign both_zero = (a_class[3] | a_class[4]) & (b_class[3] | b_class[4]);

    // Sign-magnitude total order with -0 below +0
    always_comb begin
        if (a_q[31] != b_q[31]) begin
            total_lt = a_q[31];
        end else if (a_q[31]) begin
            total_lt = a_q[30:0] > b_q[30:0];
        end else begin
            total_lt = a_q[30:0] < b_q[30:0];
        end
    end

    assign num_eq = (a_q == b_q) | both_zero;
    assign num_lt = total_lt & ~both_zero;

    always_comb begin
        result_d = 32'd0;
        fflags_d = '0;
        case (op_q)
            UOP_SGNJ:  result_d = {b_q[31], a_q[30:0]};
            UOP_SGNJN: result_d = {~b_q[31], a_q[30:0]};
            UOP_SGNJX: result_d = {a_q[31] ^ b_q[31], a_q[30:0]};
            UOP_MIN, UOP_MAX: begin
                if (a_nan && b_nan) begin
                    result_d = CANONICAL_NAN;
                end else if (a_nan) begin
                    result_d = b_q;
                end else if (b_nan) begin
                    result_d = a_q;
                end else if (op_q == UOP_MIN) begin
                    result_d = total_lt ? a_q : b_q;
                end else begin
                    result_d = total_lt ? b_q : a_q;
                end
                fflags_d[FLAG_NV] = any_snan;
            end
            UOP_FEQ: begin
                result_d[0]       = ~a_nan & ~b_nan & num_eq;
                fflags_d[FLAG_NV] = any_snan;      // Quiet compare
            end
            UOP_FLT: begin
                result_d[0]       = ~a_nan & ~b_nan & num_lt;
                fflags_d[FLAG_NV] = a_nan | b_nan;
            end
            UOP_FLE: begin
                result_d[0]       = ~a_nan & ~b_nan & (num_lt | num_eq);
                fflags_d[FLAG_NV] = a_nan | b_nan;
            end
            UOP_CLASS: result_d = {{(32 - CLASS_BITS){1'b0}}, a_class};
            default: result_d = 32'd0;
        endcase
        if (unsupported_q) begin
            result_d          = 32'd0;
            fflags_d          = '0;
            fflags_d[FLAG_NV] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            result_q <= result_d;
            fflags_q <= fflags_d;
        end
    end

    assign result_o = result_q;
    assign fflags_o = fflags_q;

endmodule

/* design/fpu_pipe_ctrl.sv */
module fpu_pipe_ctrl (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    input  logic                           valid_i,
    output logic                           ready_o,
    input  logic [fpu_pkg::TAG_BITS-1:0]   tag_i,
    input  logic                           has_fflags_i,

    output logic                           valid_o,
    input  logic                           ready_i,
    output logic [fpu_pkg::TAG_BITS-1:0]   tag_o,
    output logic                           has_fflags_o,

    output logic                           advance_o
);
    import fpu_pkg::*;

    logic                s1_valid_q;
    logic                s2_valid_q;
    logic [TAG_BITS-1:0] s1_tag_q;
    logic [TAG_BITS-1:0] s2_tag_q;
    logic                s1_has_fflags_q;
    logic                s2_has_fflags_q;

    // Whole pipe stalls as one only on a blocked full output
    assign advance_o = ~s2_valid_q | ready_i;
    assign ready_o   = advance_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (advance_o) begin
            s1_valid_q <= valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_o) begin
            s1_tag_q        <= tag_i;
            s1_has_fflags_q <= has_fflags_i;
            s2_tag_q        <= s1_tag_q;
            s2_has_fflags_q <= s1_has_fflags_q;
        end
    end

    assign valid_o      = s2_valid_q;
    assign tag_o        = s2_tag_q;
    assign has_fflags_o = s2_has_fflags_q;

endmodule

/* design/fpu_op_decode.sv */
module fpu_op_decode (
    input  fpu_pkg::fpu_op_e                 op_type_i,
    input  logic [fpu_pkg::FRM_BITS-1:0]     frm_i,
    output fpu_pkg::fpu_unit_op_e            unit_op_o,
    output logic                             has_fflags_o,
    output logic                             unsupported_o
);
    import fpu_pkg::*;

    always_comb begin
        unit_op_o     = UOP_SGNJ;
        has_fflags_o  = 1'b1;
        unsupported_o = 1'b0;
        case (op_type_i)
            FPU_CLASS: begin
                unit_op_o    = UOP_CLASS;
                has_fflags_o = 1'b0;
            end
            FPU_CMP: begin
                case (frm_i)
                    3'd0:    unit_op_o = UOP_FLE;
                    3'd1:    unit_op_o = UOP_FLT;
                    default: unit_op_o = UOP_FEQ;    // frm 2 and spare codes
                endcase
            end
            FPU_MISC: begin
                case (frm_i)
                    3'd0: begin
                        unit_op_o    = UOP_SGNJ;
                        has_fflags_o = 1'b0;
                    end
                    3'd1: begin
                        unit_op_o    = UOP_SGNJN;
                        has_fflags_o = 1'b0;
                    end
                    3'd2: begin
                        unit_op_o    = UOP_SGNJX;
                        has_fflags_o = 1'b0;
                    end
                    3'd3: begin
                        unit_op_o = UOP_MIN;
                    end
                    3'd4: begin
                        unit_op_o = UOP_MAX;
                    end
                    default: begin
                        unit_op_o    = UOP_SGNJ;
                        has_fflags_o = 1'b0;
                    end
                endcase
            end
            default: begin
                // Arithmetic and conversions live in other units
                unit_op_o     = UOP_SGNJ;
                has_fflags_o  = 1'b1;
                unsupported_o = 1'b1;
            end
        endcase
    end

endmodule

/* design/fpu_pkg.sv */
package fpu_pkg;

    localparam int NUM_THREADS     = 4;
    localparam int TAG_BITS        = 4;
    localparam int LATENCY_NONCOMP = 2;      // Two register stages from accept to transfer
    localparam int FRM_BITS        = 3;

    // Only NV of {NV, DZ, OF, UF, NX} is ever raised here
    localparam int FFLAGS_BITS = 5;
    localparam int FLAG_NV     = 4;

    localparam int          CLASS_BITS    = 10;    // One-hot classify mask width
    localparam logic [31:0] CANONICAL_NAN = 32'h7fc0_0000;

    // Core opcode in the numbering of the core's decode
    typedef enum logic [3:0] {
        FPU_ADD    = 4'd0,
        FPU_SUB    = 4'd1,
        FPU_MUL    = 4'd2,
        FPU_DIV    = 4'd3,
        FPU_SQRT   = 4'd4,
        FPU_MADD   = 4'd5,
        FPU_MSUB   = 4'd6,
        FPU_NMSUB  = 4'd7,
        FPU_NMADD  = 4'd8,
        FPU_CVTWS  = 4'd9,
        FPU_CVTWUS = 4'd10,
        FPU_CVTSW  = 4'd11,
        FPU_CVTSWU = 4'd12,
        FPU_CLASS  = 4'd13,
        FPU_CMP    = 4'd14,
        FPU_MISC   = 4'd15
    } fpu_op_e;

    // Nine lane operations need a 4-bit field
    typedef enum logic [3:0] {
        UOP_SGNJ  = 4'd0,
        UOP_SGNJN = 4'd1,
        UOP_SGNJX = 4'd2,
        UOP_MIN   = 4'd3,
        UOP_MAX   = 4'd4,
        UOP_FEQ   = 4'd5,
        UOP_FLT   = 4'd6,
        UOP_FLE   = 4'd7,
        UOP_CLASS = 4'd8
    } fpu_unit_op_e;

endpackage
